// File: tests/interconnect_input.txt
// columns: request frame, expected response frame, expected parity (all hex)
// request bit 18 marks a write, bits 17:16 the address; with bit 18 clear it is a poll
00000 00000 0 // first poll after reset
41234 00000 0 // loopback write, address 0
00000 41234 0
5beef 00000 1 // output crossbar data, address 1
00000 5beef 0
60001 00000 1 // input crossbar sends to output 1
70002 00000 0 // output crossbar takes input 1
40010 00000 0 // sample a
40003 00000 1 // sample b
40005 00000 1 // sample c
40020 00000 0 // sample d
00000 50038 0 // a+b+c+d
00000 5fff2 0 // a-b+c-d
00000 5ffee 0 // a+b-c-d
00000 50028 0 // a-b-c+d
00000 00000 0
2abcd 00000 1 // poll carrying address and data has no effect
00000 00000 0
60000 00000 0 // back to default selections
70000 00000 1
4a5a5 00000 1
00000 4a5a5 0

// File: spi_interconnect.f
common/interconnect_pkg.sv
spi/spi_minion.sv
hdl/msg_router.sv
hdl/msg_arbiter.sv
hdl/stream_crossbar.sv
transform/wht_unit.sv
hdl/spi_interconnect.sv
tests/tb_spi_interconnect.sv

// File: Bender.yml
package:
  name: spi_interconnect

sources:
  - common/interconnect_pkg.sv
  - spi/spi_minion.sv
  - hdl/msg_router.sv
  - hdl/msg_arbiter.sv
  - hdl/stream_crossbar.sv
  - transform/wht_unit.sv
  - hdl/spi_interconnect.sv
  - target: test
    files:
      - tests/tb_spi_interconnect.sv

// File: tests/tb_spi_interconnect.sv
module tb_spi_interconnect;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FRAME_W     = 19;
  localparam int MAX_VECTORS = 64;
  localparam int HALF_MIN    = 4;
  // cs is seen one edge after it is driven, parity follows three edges later
  localparam int PARITY_DELAY   = 4;
  localparam int PARITY_TIMEOUT = 32;
  localparam logic [31:0] LFSR_SEED = 32'h9978_2b6a;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic clk;
  logic rst_n;
  logic cs;
  logic sclk;
  logic mosi;
  logic miso;
  logic minion_parity;

  // three words per transaction: request, response, parity
  logic [19:0] vectors [3*MAX_VECTORS];
  logic [31:0] lfsr_state;
  int          mismatch_count;
  int          timeout_count;
  int          setup_count;
  int          num_vectors;

  spi_interconnect i_spi_interconnect (
    .clk           (clk),
    .rst_n         (rst_n),
    .cs            (cs),
    .sclk          (sclk),
    .mosi          (mosi),
    .miso          (miso),
    .minion_parity (minion_parity)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ LFSR_TAPS;
    end
    return next;
  endfunction

  // the bit shifted out of the lfsr is the one taken
  task automatic take_random_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // spi mode 0 host, one full-duplex frame msb first
  task automatic spi_transfer(input logic [FRAME_W-1:0] request, input int half,
                              output logic [FRAME_W-1:0] response);
    response = '0;
    @(posedge clk);
    cs   <= 1'b0;
    sclk <= 1'b0;
    mosi <= request[FRAME_W-1];
    for (int i = FRAME_W - 1; i >= 0; i--) begin
      repeat (half - 1) @(posedge clk);
      // miso has settled well before the rising sclk
      @(negedge clk);
      response[i] = miso;
      @(posedge clk);
      sclk <= 1'b1;
      repeat (half) @(posedge clk);
      sclk <= 1'b0;
      if (i > 0) begin
        mosi <= request[i-1];
      end
    end
    repeat (half) @(posedge clk);
    cs <= 1'b1;
  endtask

  task automatic check_parity(input int index, input logic exp_parity);
    int cycles;
    cycles = 0;
    while (cycles < PARITY_TIMEOUT &&
           (cycles < PARITY_DELAY || minion_parity !== exp_parity)) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= PARITY_TIMEOUT && minion_parity !== exp_parity) begin
      $display("timeout: minion_parity did not settle within %0d cycles after transaction %0d",
               PARITY_TIMEOUT, index);
      timeout_count++;
    end
    assert (minion_parity === exp_parity) else begin
      $display("FAILED minion_parity at transaction %0d: got %0h, expected %0h",
               index, minion_parity, exp_parity);
      mismatch_count++;
    end
  endtask

  initial begin
    int              half;
    int              extra;
    logic [19:0]     request;
    logic [FRAME_W-1:0] response;

    clk            = 1'b0;
    rst_n          = 1'b0;
    cs             = 1'b1;
    sclk           = 1'b0;
    mosi           = 1'b0;
    lfsr_state     = LFSR_SEED;
    mismatch_count = 0;
    timeout_count  = 0;
    setup_count    = 0;

    // entries past the end of the file keep bit 19 set
    for (int a = 0; a < 3 * MAX_VECTORS; a++) begin
      vectors[a] = {1'b1, 19'(a)};
    end
    $readmemh("tests/interconnect_input.txt", vectors);
    num_vectors = 0;
    while (num_vectors < MAX_VECTORS && !vectors[3*num_vectors][19]) begin
      num_vectors++;
    end
    if (num_vectors == 0) begin
      $display("no transactions could be read from tests/interconnect_input.txt");
      setup_count++;
    end

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    // outputs straight after reset
    @(negedge clk);
    assert (minion_parity === 1'b0) else begin
      $display("FAILED minion_parity after reset: got %0h, expected 0", minion_parity);
      mismatch_count++;
    end
    assert (miso === 1'b0) else begin
      $display("FAILED miso after reset: got %0h, expected 0", miso);
      mismatch_count++;
    end

    for (int n = 0; n < num_vectors; n++) begin
      request = vectors[3*n];
      take_random_bits(2, extra);
      half = HALF_MIN + extra;
      spi_transfer(request[FRAME_W-1:0], half, response);
      assert (response === vectors[3*n+1][FRAME_W-1:0]) else begin
        $display("FAILED miso response at transaction %0d: got %05h, expected %05h",
                 n, response, vectors[3*n+1][FRAME_W-1:0]);
        mismatch_count++;
      end
      check_parity(n, vectors[3*n+2][0]);
      // cs idles high for a half period between frames
      repeat (half) @(posedge clk);
    end

    $display("errors: %0d mismatches, %0d timeouts, %0d setup errors",
             mismatch_count, timeout_count, setup_count);
    if (mismatch_count + timeout_count + setup_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: hdl/spi_interconnect.sv
module spi_interconnect (
  input  logic clk,
  input  logic rst_n,
  input  logic cs,
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  output logic minion_parity
);
  import interconnect_pkg::*;

  localparam int N_DEST = 2**addr_w;

  logic                     spi_recv_val;
  logic                     spi_recv_rdy;
  logic [addr_w+data_w-1:0] spi_recv_msg;
  logic                     spi_send_val;
  logic                     spi_send_rdy;
  logic [data_w:0]          spi_send_msg;

  logic              router_val [N_DEST];
  logic              router_rdy [N_DEST];
  logic [data_w-1:0] router_msg [N_DEST];

  logic              in_xbar_recv_val [1];
  logic              in_xbar_recv_rdy [1];
  logic [data_w-1:0] in_xbar_recv_msg [1];
  logic              in_xbar_send_val [2];
  logic              in_xbar_send_rdy [2];
  logic [data_w-1:0] in_xbar_send_msg [2];

  logic              out_xbar_recv_val [2];
  logic              out_xbar_recv_rdy [2];
  logic [data_w-1:0] out_xbar_recv_msg [2];
  logic              out_xbar_send_val [1];
  logic              out_xbar_send_rdy [1];
  logic [data_w-1:0] out_xbar_send_msg [1];

  logic              arb_val [2];
  logic              arb_rdy [2];
  logic [data_w-1:0] arb_msg [2];

  spi_minion i_spi_minion (
    .clk           (clk),
    .rst_n         (rst_n),
    .cs            (cs),
    .sclk          (sclk),
    .mosi          (mosi),
    .miso          (miso),
    .recv_val      (spi_recv_val),
    .recv_rdy      (spi_recv_rdy),
    .recv_msg      (spi_recv_msg),
    .send_val      (spi_send_val),
    .send_rdy      (spi_send_rdy),
    .send_msg      (spi_send_msg),
    .minion_parity (minion_parity)
  );

  msg_router i_msg_router (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_val  (spi_recv_val),
    .in_rdy  (spi_recv_rdy),
    .in_msg  (spi_recv_msg),
    .out_val (router_val),
    .out_rdy (router_rdy),
    .out_msg (router_msg)
  );

  // host data into the input crossbar
  assign in_xbar_recv_val[0]        = router_val[addr_loop_data];
  assign in_xbar_recv_msg[0]        = router_msg[addr_loop_data];
  assign router_rdy[addr_loop_data] = in_xbar_recv_rdy[0];

  stream_crossbar #(
    .N_INPUTS  (1),
    .N_OUTPUTS (2)
  ) in_xbar (
    .clk         (clk),
    .rst_n       (rst_n),
    .recv_val    (in_xbar_recv_val),
    .recv_rdy    (in_xbar_recv_rdy),
    .recv_msg    (in_xbar_recv_msg),
    .send_val    (in_xbar_send_val),
    .send_rdy    (in_xbar_send_rdy),
    .send_msg    (in_xbar_send_msg),
    .control_val (router_val[addr_in_cfg]),
    .control_rdy (router_rdy[addr_in_cfg]),
    .control     (router_msg[addr_in_cfg][cfg_w-1:0])
  );

  // output 1 of the input crossbar feeds the transform
  wht_unit i_wht_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .recv_val (in_xbar_send_val[1]),
    .recv_rdy (in_xbar_send_rdy[1]),
    .recv_msg (in_xbar_send_msg[1]),
    .send_val (out_xbar_recv_val[1]),
    .send_rdy (out_xbar_recv_rdy[1]),
    .send_msg (out_xbar_recv_msg[1])
  );

  assign out_xbar_recv_val[0]      = router_val[addr_out_data];
  assign out_xbar_recv_msg[0]      = router_msg[addr_out_data];
  assign router_rdy[addr_out_data] = out_xbar_recv_rdy[0];

  stream_crossbar #(
    .N_INPUTS  (2),
    .N_OUTPUTS (1)
  ) out_xbar (
    .clk         (clk),
    .rst_n       (rst_n),
    .recv_val    (out_xbar_recv_val),
    .recv_rdy    (out_xbar_recv_rdy),
    .recv_msg    (out_xbar_recv_msg),
    .send_val    (out_xbar_send_val),
    .send_rdy    (out_xbar_send_rdy),
    .send_msg    (out_xbar_send_msg),
    .control_val (router_val[addr_out_cfg]),
    .control_rdy (router_rdy[addr_out_cfg]),
    .control     (router_msg[addr_out_cfg][cfg_w-1:0])
  );

  // return streams, source 0 is loopback and source 1 the output crossbar
  assign arb_val[0]          = in_xbar_send_val[0];
  assign arb_msg[0]          = in_xbar_send_msg[0];
  assign in_xbar_send_rdy[0] = arb_rdy[0];

  assign arb_val[1]           = out_xbar_send_val[0];
  assign arb_msg[1]           = out_xbar_send_msg[0];
  assign out_xbar_send_rdy[0] = arb_rdy[1];

  msg_arbiter #(
    .N_INPUTS (2)
  ) i_msg_arbiter (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_val  (arb_val),
    .in_rdy  (arb_rdy),
    .in_msg  (arb_msg),
    .out_val (spi_send_val),
    .out_rdy (spi_send_rdy),
    .out_msg (spi_send_msg)
  );

endmodule

// File: transform/wht_unit.sv
module wht_unit (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                recv_val,
  output logic                                recv_rdy,
  input  logic [interconnect_pkg::data_w-1:0] recv_msg,
  output logic                                send_val,
  input  logic                                send_rdy,
  output logic [interconnect_pkg::data_w-1:0] send_msg
);
  import interconnect_pkg::*;

  localparam int CNT_W = $clog2(wht_points);

  wht_state_t state;
  logic [CNT_W-1:0] cnt;

  logic [data_w-1:0] x [wht_points];
  logic [data_w-1:0] y [wht_points];

  // first butterfly stage
  logic [data_w-1:0] sum_ab;
  logic [data_w-1:0] dif_ab;
  logic [data_w-1:0] sum_cd;
  logic [data_w-1:0] dif_cd;

  logic last;

  assign recv_rdy = (state == wht_collect);
  assign send_val = (state == wht_emit);
  assign send_msg = y[cnt];

  assign last = (cnt == CNT_W'(wht_points - 1));

  assign sum_ab = x[0] + x[1];
  assign dif_ab = x[0] - x[1];
  assign sum_cd = x[2] + x[3];
  assign dif_cd = x[2] - x[3];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= wht_collect;
      cnt   <= '0;
    end else begin
      case (state)
        wht_collect: begin
          if (recv_val && recv_rdy) begin
            cnt <= cnt + 1'b1;
            if (last) begin
              state <= wht_compute;
            end
          end
        end
        wht_compute: begin
          state <= wht_emit;
          cnt   <= '0;
        end
        wht_emit: begin
          if (send_rdy) begin
            cnt <= cnt + 1'b1;
            if (last) begin
              state <= wht_collect;
            end
          end
        end
        default: state <= wht_collect;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == wht_collect && recv_val) begin
      x[cnt] <= recv_msg;
    end
  end

  // second butterfly stage, everything wraps at data_w bits
  always_ff @(posedge clk) begin
    if (state == wht_compute) begin
      y[0] <= sum_ab + sum_cd;
      y[1] <= dif_ab + dif_cd;
      y[2] <= sum_ab - sum_cd;
      y[3] <= dif_ab - dif_cd;
    end
  end

endmodule

// File: hdl/stream_crossbar.sv
module stream_crossbar #(
  parameter int N_INPUTS  = 2,
  parameter int N_OUTPUTS = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  recv_val [N_INPUTS],
  output logic                                  recv_rdy [N_INPUTS],
  input  logic [interconnect_pkg::data_w-1:0]   recv_msg [N_INPUTS],
  output logic                                  send_val [N_OUTPUTS],
  input  logic                                  send_rdy [N_OUTPUTS],
  output logic [interconnect_pkg::data_w-1:0]   send_msg [N_OUTPUTS],
  input  logic                                  control_val,
  output logic                                  control_rdy,
  input  logic [interconnect_pkg::cfg_w-1:0]    control
);
  import interconnect_pkg::*;

  localparam int IN_W  = (N_INPUTS > 1) ? $clog2(N_INPUTS) : 1;
  localparam int OUT_W = (N_OUTPUTS > 1) ? $clog2(N_OUTPUTS) : 1;

  logic [IN_W-1:0]  in_sel;
  logic [OUT_W-1:0] out_sel;

  // a new selection can always be taken
  assign control_rdy = 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_sel  <= '0;
      out_sel <= '0;
    end else if (control_val && control_rdy) begin
      // indices wrap to the number of ports
      in_sel  <= IN_W'(int'(control[1]) % N_INPUTS);
      out_sel <= OUT_W'(int'(control[0]) % N_OUTPUTS);
    end
  end

  always_comb begin
    for (int o = 0; o < N_OUTPUTS; o++) begin
      send_val[o] = 1'b0;
      send_msg[o] = recv_msg[in_sel];
    end
    for (int i = 0; i < N_INPUTS; i++) begin
      recv_rdy[i] = 1'b0;
    end
    // one path through, unselected ports stay idle
    send_val[out_sel] = recv_val[in_sel];
    recv_rdy[in_sel]  = send_rdy[out_sel];
  end

endmodule

// File: hdl/msg_arbiter.sv
module msg_arbiter #(
  parameter  int N_INPUTS = 2,
  localparam int SRC_W    = (N_INPUTS > 1) ? $clog2(N_INPUTS) : 1
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    in_val [N_INPUTS],
  output logic                                    in_rdy [N_INPUTS],
  input  logic [interconnect_pkg::data_w-1:0]     in_msg [N_INPUTS],
  output logic                                    out_val,
  input  logic                                    out_rdy,
  output logic [SRC_W+interconnect_pkg::data_w-1:0] out_msg
);
  import interconnect_pkg::*;

  logic [SRC_W-1:0] prio;
  logic [SRC_W-1:0] grant;
  logic             grant_found;
  logic             take;

  // first valid input at or after the priority pointer wins
  always_comb begin
    int idx;
    grant_found = 1'b0;
    grant       = '0;
    for (int k = 0; k < N_INPUTS; k++) begin
      idx = (int'(prio) + k) % N_INPUTS;
      if (!grant_found && in_val[idx]) begin
        grant_found = 1'b1;
        grant       = SRC_W'(idx);
      end
    end
  end

  // buffer takes a word when empty or drained this cycle
  assign take = grant_found && (!out_val || out_rdy);

  always_comb begin
    for (int i = 0; i < N_INPUTS; i++) begin
      in_rdy[i] = take && (grant == SRC_W'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_val <= 1'b0;
      prio    <= '0;
    end else if (take) begin
      out_val <= 1'b1;
      prio    <= SRC_W'((int'(grant) + 1) % N_INPUTS);
    end else if (out_rdy) begin
      out_val <= 1'b0;
    end
  end

  // word is tagged with the index of the input it came from
  always_ff @(posedge clk) begin
    if (take) begin
      out_msg <= {grant, in_msg[grant]};
    end
  end

endmodule

// File: hdl/msg_router.sv
module msg_router (
  input  logic                                                       clk,
  input  logic                                                       rst_n,
  input  logic                                                       in_val,
  output logic                                                       in_rdy,
  input  logic [interconnect_pkg::addr_w+interconnect_pkg::data_w-1:0] in_msg,
  output logic                                  out_val [2**interconnect_pkg::addr_w],
  input  logic                                  out_rdy [2**interconnect_pkg::addr_w],
  output logic [interconnect_pkg::data_w-1:0]   out_msg [2**interconnect_pkg::addr_w]
);
  import interconnect_pkg::*;

  localparam int N_DEST = 2**addr_w;

  addr_t dest;

  assign dest = addr_t'(in_msg[data_w +: addr_w]);

  always_comb begin
    for (int i = 0; i < N_DEST; i++) begin
      out_val[i] = in_val && (int'(dest) == i);
      out_msg[i] = in_msg[data_w-1:0];
    end
  end

  // ready comes back from the addressed destination only
  assign in_rdy = out_rdy[dest];

endmodule

// File: spi/spi_minion.sv
module spi_minion (
  input  logic                                                       clk,
  input  logic                                                       rst_n,
  input  logic                                                       cs,
  input  logic                                                       sclk,
  input  logic                                                       mosi,
  output logic                                                       miso,
  output logic                                                       recv_val,
  input  logic                                                       recv_rdy,
  output logic [interconnect_pkg::addr_w+interconnect_pkg::data_w-1:0] recv_msg,
  input  logic                                                       send_val,
  output logic                                                       send_rdy,
  input  logic [interconnect_pkg::data_w:0]                          send_msg,
  output logic                                                       minion_parity
);
  import interconnect_pkg::*;

  localparam int CNT_W = $clog2(frame_w + 1);

  // stages 0 and 1 synchronize, stage 2 is kept for edge detection
  logic [2:0] cs_sync;
  logic [2:0] sclk_sync;
  logic [1:0] mosi_sync;

  logic cs_fall;
  logic cs_rise;
  logic sclk_rise;
  logic sclk_fall;
  logic frame_end;
  logic recv_free;

  spi_state_t state;
  logic [CNT_W-1:0] bit_cnt;
  logic [frame_w-1:0] shift_in;
  logic [frame_w-1:0] shift_out;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cs_sync   <= '1;
      sclk_sync <= '0;
      mosi_sync <= '0;
    end else begin
      cs_sync   <= {cs_sync[1:0], cs};
      sclk_sync <= {sclk_sync[1:0], sclk};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign cs_fall   = cs_sync[2] & ~cs_sync[1];
  assign cs_rise   = ~cs_sync[2] & cs_sync[1];
  assign sclk_rise = ~sclk_sync[2] & sclk_sync[1];
  assign sclk_fall = sclk_sync[2] & ~sclk_sync[1];

  // only a frame with all bits clocked in counts at cs rise
  assign frame_end = (state == spi_done) && cs_rise;
  assign recv_free = !recv_val || recv_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= spi_idle;
      bit_cnt <= '0;
    end else begin
      case (state)
        spi_idle: begin
          if (cs_fall) begin
            state   <= spi_shift;
            bit_cnt <= '0;
          end
        end
        spi_shift: begin
          if (cs_rise) begin
            state <= spi_idle;
          end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == CNT_W'(frame_w - 1)) begin
              state <= spi_done;
            end
          end
        end
        spi_done: begin
          if (cs_rise) begin
            state <= spi_idle;
          end
        end
        default: state <= spi_idle;
      endcase
    end
  end

  // mosi sampled on rising sclk, msb first
  always_ff @(posedge clk) begin
    if (state == spi_shift && sclk_rise) begin
      shift_in <= {shift_in[frame_w-2:0], mosi_sync[1]};
    end
  end

  // response is taken from the arbiter only at cs fall
  assign send_rdy = (state == spi_idle) && cs_fall;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_out <= '0;
    end else if (send_rdy) begin
      shift_out <= send_val ? {1'b1, 1'b0, send_msg} : '0;
    end else if (state != spi_idle && sclk_fall) begin
      shift_out <= {shift_out[frame_w-2:0], 1'b0};
    end
  end

  assign miso = shift_out[frame_w-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      recv_val      <= 1'b0;
      minion_parity <= 1'b0;
    end else begin
      if (recv_val && recv_rdy) begin
        recv_val <= 1'b0;
      end
      if (frame_end) begin
        minion_parity <= ^shift_in;
        // a write that overruns a pending frame is dropped
        if (shift_in[frame_valid_bit] && recv_free) begin
          recv_val <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frame_end && shift_in[frame_valid_bit] && recv_free) begin
      recv_msg <= shift_in[frame_valid_bit-1:0];
    end
  end

endmodule

// File: common/interconnect_pkg.sv
package interconnect_pkg;

  // stream and frame widths
  localparam int data_w  = 16;
  localparam int addr_w  = 2;
  localparam int frame_w = 1 + addr_w + data_w;

  // request: write-valid, response: response-valid
  localparam int frame_valid_bit = frame_w - 1;

  // crossbar control word, bit 1 selects the input and bit 0 the output
  localparam int cfg_w = 2;

  // transform size
  localparam int wht_points = 4;

  // router destinations, one per frame address
  typedef enum logic [addr_w-1:0] {
    addr_loop_data = 2'd0,
    addr_out_data  = 2'd1,
    addr_in_cfg    = 2'd2,
    addr_out_cfg   = 2'd3
  } addr_t;

  typedef enum logic [1:0] {
    wht_collect,
    wht_compute,
    wht_emit
  } wht_state_t;

  typedef enum logic [1:0] {
    spi_idle,
    spi_shift,
    spi_done
  } spi_state_t;

endpackage
